//--- design/obj_pkg.sv
//**************************************************************************
// Object engine package
// Table geometry, graphics ROM addressing and the structs that carry
// bus requests, draw jobs and line buffer writes between the blocks
//**************************************************************************

package obj_pkg;

    // Object table
    localparam int OBJ_COUNT   = 16;
    localparam int ENTRY_BYTES = 4;
    localparam int TABLE_AW    = 6;

    // Line buffer and sprite size
    localparam int LINE_W = 256;
    localparam int SPR_H  = 16;

    // Graphics ROM address is {code, row}
    localparam int ROM_AW = 12;

    typedef struct packed {
        logic [TABLE_AW-1:0] paddr;
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [7:0]          pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                req;
        logic [TABLE_AW-1:0] addr;
    } ram_rd_t;

    // Row is already flipped for vflip
    typedef struct packed {
        logic [7:0] code;
        logic [3:0] row;
        logic [7:0] xpos;
        logic [3:0] pal;
        logic       hflip;
    } draw_job_t;

    // Data is {pal, color}
    typedef struct packed {
        logic       en;
        logic [7:0] addr;
        logic [7:0] data;
    } lb_wr_t;

endpackage

//--- design/obj_ram_arbiter.sv
//**************************************************************************
// Object table RAM arbiter
// Single-port 64-byte table shared by the APB slave and the line scanner,
// with APB access cycles taking priority over scanner reads
//**************************************************************************

`timescale 1ns/100ps

module obj_ram_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  obj_pkg::apb_req_t apb,
    output logic              pready,
    output logic [7:0]        prdata,
    input  obj_pkg::ram_rd_t  rd,
    output logic              rd_valid,
    output logic [7:0]        rd_data
);

    localparam int DEPTH = obj_pkg::OBJ_COUNT * obj_pkg::ENTRY_BYTES;

    logic                         apb_grant;
    logic                         rd_grant;
    logic [obj_pkg::TABLE_AW-1:0] addr;
    logic [7:0]                   mem [DEPTH];
    logic [7:0]                   q;

    // An access cycle is served once, pready marks it as done
    assign apb_grant = apb.psel & apb.penable & ~pready;

    // Scanner only gets the RAM when no APB access waits,
    // and not again while its previous result is being returned
    assign rd_grant = rd.req & ~apb_grant & ~rd_valid;

    assign addr = apb_grant ? apb.paddr : rd.addr;

    always_ff @(posedge clk) begin
        if (apb_grant && apb.pwrite) begin
            mem[addr] <= apb.pwdata;
        end
        q <= mem[addr];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pready   <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            pready   <= apb_grant;
            rd_valid <= rd_grant;
        end
    end

    // Same read register serves both requesters
    assign prdata  = q;
    assign rd_data = q;

endmodule

//--- design/obj_scan.sv
//**************************************************************************
// Object table scanner
// Walks the 16 entries at each line start, checks which sprites cover
// the line being prepared and hands them to the draw engine
//**************************************************************************

`timescale 1ns/100ps

module obj_scan (
    input  logic               clk,
    input  logic               rst,
    input  logic               line_start,
    input  logic [7:0]         vrender,
    output obj_pkg::ram_rd_t   rd,
    input  logic               rd_valid,
    input  logic [7:0]         rd_data,
    output logic               job_valid,
    output obj_pkg::draw_job_t job,
    input  logic               job_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_READ,
        S_ISSUE
    } state_t;

    state_t     state;
    logic [3:0] idx;
    logic [1:0] byte_sel;
    logic [7:0] y_r;
    logic [7:0] x_r;
    logic [7:0] code_r;
    logic [7:0] diff;
    logic       in_zone;
    logic       last;

    // Line offset inside the sprite, wraps modulo 256
    assign diff    = vrender - y_r;
    assign in_zone = diff < 8'(obj_pkg::SPR_H);
    assign last    = idx == 4'(obj_pkg::OBJ_COUNT - 1);

    assign rd.req  = state == S_READ;
    assign rd.addr = {idx, byte_sel};

    // Entry bytes arrive as y, x, code, attr
    always_ff @(posedge clk) begin
        if (state == S_READ && rd_valid) begin
            case (byte_sel)
                2'd0: y_r <= rd_data;
                2'd1: x_r <= rd_data;
                2'd2: code_r <= rd_data;
                default: begin
                    job.code  <= code_r;
                    job.row   <= rd_data[5] ? ~diff[3:0] : diff[3:0];
                    job.xpos  <= x_r;
                    job.pal   <= rd_data[3:0];
                    job.hflip <= rd_data[4];
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            idx       <= '0;
            byte_sel  <= '0;
            job_valid <= 1'b0;
        end else if (line_start) begin
            // A scan still running is dropped here
            state     <= S_START;
            idx       <= '0;
            byte_sel  <= '0;
            job_valid <= 1'b0;
        end else begin
            case (state)
                // One quiet cycle so a late read result gets ignored
                S_START: state <= S_READ;
                S_READ: begin
                    if (rd_valid) begin
                        byte_sel <= byte_sel + 2'd1;
                        if (byte_sel == 2'd3) begin
                            if (in_zone) begin
                                job_valid <= 1'b1;
                                state     <= S_ISSUE;
                            end else if (last) begin
                                state <= S_IDLE;
                            end else begin
                                idx <= idx + 4'd1;
                            end
                        end
                    end
                end
                S_ISSUE: begin
                    if (job_ready) begin
                        job_valid <= 1'b0;
                        if (last) begin
                            state <= S_IDLE;
                        end else begin
                            idx   <= idx + 4'd1;
                            state <= S_READ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- design/obj_draw.sv
//**************************************************************************
// Sprite draw engine
// Fetches one 8-pixel row from the graphics ROM and writes its opaque
// pixels into the line buffer, one pixel per clock
//**************************************************************************

`timescale 1ns/100ps

module obj_draw (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       job_valid,
    input  obj_pkg::draw_job_t         job,
    output logic                       job_ready,
    output logic                       rom_cs,
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    input  logic [31:0]                rom_data,
    input  logic                       rom_ok,
    output obj_pkg::lb_wr_t            lb_wr
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_DRAW,
        D_GAP
    } state_t;

    state_t             state;
    obj_pkg::draw_job_t job_r;
    logic [31:0]        row_r;
    logic [2:0]         k;
    logic [2:0]         koff;
    logic [8:0]         xsum;
    logic [3:0]         color;

    assign job_ready = state == D_IDLE;

    // 7 - k is the bitwise inverse for a 3-bit count
    assign koff  = job_r.hflip ? ~k : k;
    assign xsum  = {1'b0, job_r.xpos} + {6'd0, koff};
    assign color = row_r[{k, 2'b00} +: 4];

    // Color 0 is transparent, pixels past x = 255 are clipped
    assign lb_wr.en   = state == D_DRAW && color != 4'd0 && !xsum[8];
    assign lb_wr.addr = xsum[7:0];
    assign lb_wr.data = {job_r.pal, color};

    always_ff @(posedge clk) begin
        if (job_valid && job_ready) begin
            job_r    <= job;
            rom_addr <= {job.code, job.row};
        end
        if (state == D_FETCH && rom_ok) begin
            row_r <= rom_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= D_IDLE;
            rom_cs <= 1'b0;
            k      <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (job_valid) begin
                        rom_cs <= 1'b1;
                        state  <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        k      <= '0;
                        state  <= D_DRAW;
                    end
                end
                D_DRAW: begin
                    k <= k + 3'd1;
                    if (k == 3'd7) begin
                        state <= D_GAP;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

endmodule

//--- design/obj_line_buffer.sv
//**************************************************************************
// Double line buffer
// Back half takes draw writes, front half is read out on the pixel
// enable and cleared behind the read, halves swap at line start
//**************************************************************************

`timescale 1ns/100ps

module obj_line_buffer (
    input  logic            clk,
    input  logic            rst,
    input  logic            line_start,
    input  logic            pxl_cen,
    input  logic [7:0]      hdump,
    input  obj_pkg::lb_wr_t lb_wr,
    output logic [7:0]      pxl
);

    localparam int DEPTH = 2 * obj_pkg::LINE_W;

    logic [7:0]       mem [DEPTH];
    logic [DEPTH-1:0] valid;
    logic             sel;
    logic [8:0]       wr_addr;
    logic [8:0]       rd_addr;

    // sel picks the front half
    assign wr_addr = {~sel, lb_wr.addr};
    assign rd_addr = {sel, hdump};

    always_ff @(posedge clk) begin
        if (lb_wr.en) begin
            mem[wr_addr] <= lb_wr.data;
        end
    end

    // Valid bits give the cleared state, so the RAM needs no clear write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel   <= 1'b0;
            valid <= '0;
            pxl   <= 8'd0;
        end else begin
            if (line_start) begin
                sel <= ~sel;
            end
            if (lb_wr.en) begin
                valid[wr_addr] <= 1'b1;
            end
            if (pxl_cen) begin
                pxl            <= valid[rd_addr] ? mem[rd_addr] : 8'd0;
                valid[rd_addr] <= 1'b0;
            end
        end
    end

endmodule

//--- design/obj_engine.sv
//**************************************************************************
// Scanline sprite engine
// APB object table, per-line scanner, ROM draw engine and double line
// buffer, with one line of latency from vrender to pixel output
//**************************************************************************

`timescale 1ns/100ps

module obj_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  obj_pkg::apb_req_t          apb,
    output logic                       pready,
    output logic [7:0]                 prdata,
    input  logic                       line_start,
    input  logic [7:0]                 vrender,
    input  logic [7:0]                 hdump,
    input  logic                       pxl_cen,
    output logic                       rom_cs,
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    input  logic [31:0]                rom_data,
    input  logic                       rom_ok,
    output logic [7:0]                 pxl
);

    obj_pkg::ram_rd_t   rd;
    logic               rd_valid;
    logic [7:0]         rd_data;
    logic               job_valid;
    logic               job_ready;
    obj_pkg::draw_job_t job;
    obj_pkg::lb_wr_t    lb_wr;

    obj_ram_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .apb      (apb),
        .pready   (pready),
        .prdata   (prdata),
        .rd       (rd),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .rd         (rd),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .job_valid  (job_valid),
        .job        (job),
        .job_ready  (job_ready)
    );

    obj_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .lb_wr     (lb_wr)
    );

    obj_line_buffer u_line_buffer (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .lb_wr      (lb_wr),
        .pxl        (pxl)
    );

endmodule

//--- test/obj_engine_tb.sv
//**************************************************************************
// Sprite engine testbench
// APB table setup, graphics ROM model with random latency and a
// reference renderer that checks every displayed pixel
//**************************************************************************

`timescale 1ns/100ps

module obj_engine_tb;

    localparam int TABLE_BYTES = obj_pkg::OBJ_COUNT * obj_pkg::ENTRY_BYTES;
    localparam int LINE_CLKS   = 640;
    localparam int TIMEOUT     = 100;

    logic                       clk = 1'b0;
    logic                       rst;
    obj_pkg::apb_req_t          apb;
    logic                       pready;
    logic [7:0]                 prdata;
    logic                       line_start;
    logic [7:0]                 vrender;
    logic [7:0]                 hdump;
    logic                       pxl_cen;
    logic                       rom_cs;
    logic [obj_pkg::ROM_AW-1:0] rom_addr;
    logic [31:0]                rom_data = '0;
    logic                       rom_ok = 1'b0;
    logic [7:0]                 pxl;

    int         seed;
    logic [7:0] obj_table [TABLE_BYTES];
    logic [7:0] exp_next [obj_pkg::LINE_W];
    logic [7:0] exp_disp [obj_pkg::LINE_W];
    int         lat_tab [256];
    int         rom_wait = 0;
    int         rom_reqs = 0;
    logic [11:0] rom_req_addr = '0;
    logic       cen_d = 1'b0;
    logic [7:0] hd_d = '0;
    int         pix_checks = 0;
    int         pix_errors = 0;
    int         seq_checks;
    int         seq_errors;
    int         err_base;
    string      cur_test;

    always #5 clk = ~clk;

    obj_engine dut0 (
        .clk        (clk),
        .rst        (rst),
        .apb        (apb),
        .pready     (pready),
        .prdata     (prdata),
        .line_start (line_start),
        .vrender    (vrender),
        .hdump      (hdump),
        .pxl_cen    (pxl_cen),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .pxl        (pxl)
    );

    // Each ROM byte is an address byte mixed with a constant
    function automatic logic [31:0] rom_word(input logic [11:0] a);
        return {a[11:4] ^ 8'h5a, a[7:0] ^ 8'h0f, a[11:4] ^ 8'hf0, a[7:0] ^ 8'h33};
    endfunction

    // Expected pixel at x = h for line v with later entries drawn on top
    function automatic logic [7:0] ref_pixel(input int h, input logic [7:0] v);
        logic [7:0]  res;
        logic [7:0]  diff;
        logic [7:0]  x;
        logic [7:0]  attr;
        logic [3:0]  row;
        logic [3:0]  color;
        logic [31:0] w;
        int          e;
        int          k;
        int          xs;
        res = 8'h00;
        for (e = 0; e < obj_pkg::OBJ_COUNT; e++) begin
            diff = v - obj_table[4 * e];
            x    = obj_table[4 * e + 1];
            attr = obj_table[4 * e + 3];
            if (diff < 8'd16) begin
                row = attr[5] ? 4'd15 - diff[3:0] : diff[3:0];
                w   = rom_word({obj_table[4 * e + 2], row});
                for (k = 0; k < 8; k++) begin
                    xs    = int'(x) + (attr[4] ? 7 - k : k);
                    color = w[4 * k +: 4];
                    if (xs == h && color != 4'd0) begin
                        res = {attr[3:0], color};
                    end
                end
            end
        end
        return res;
    endfunction

    // ROM answers a held request after a latency taken from the table
    always @(posedge clk) begin
        rom_ok <= 1'b0;
        if (rom_wait > 0) begin
            if (!rom_cs || rom_addr !== rom_req_addr) begin
                seq_errors++;
                $display("%s: ROM request was dropped or changed before rom_ok",
                         cur_test);
            end
            rom_wait <= rom_wait - 1;
            if (rom_wait == 1) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr);
            end
        end else if (rom_cs && !rom_ok) begin
            rom_req_addr <= rom_addr;
            rom_wait     <= lat_tab[rom_reqs % 256];
            rom_reqs     <= rom_reqs + 1;
        end
    end

    always @(posedge clk) begin
        cen_d <= pxl_cen;
        hd_d  <= hdump;
    end

    // pxl holds the pixel addressed at the last pxl_cen
    always @(negedge clk) begin
        if (cen_d) begin
            pix_checks = pix_checks + 1;
            if (pxl !== exp_disp[hd_d]) begin
                pix_errors = pix_errors + 1;
                $display("** Error %s: pixel %0d expected %02h, actual %02h",
                         cur_test, hd_d, exp_disp[hd_d], pxl);
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $finish;
    endtask

    task automatic apb_xfer(input logic wr, input logic [5:0] a, input logic [7:0] d,
                            output logic [7:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        apb.paddr   <= a;
        apb.pwrite  <= wr;
        apb.pwdata  <= d;
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        @(posedge clk);
        apb.penable <= 1'b1;
        @(posedge clk);
        while (!pready && n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (!pready) begin
            abort_run("APB transfer timed out waiting for pready");
        end else begin
            rdata = prdata;
            apb.psel    <= 1'b0;
            apb.penable <= 1'b0;
            if (wr) begin
                obj_table[a] = d;
            end
        end
    endtask

    task automatic apb_write(input logic [5:0] a, input logic [7:0] d);
        logic [7:0] dummy;
        apb_xfer(1'b1, a, d, dummy);
    endtask

    task automatic apb_check(input logic [5:0] a);
        logic [7:0] got;
        apb_xfer(1'b0, a, 8'h00, got);
        seq_checks++;
        if (got !== obj_table[a]) begin
            seq_errors++;
            $display("** Error %s: byte %0d expected %02h, actual %02h",
                     cur_test, a, obj_table[a], got);
        end
    endtask

    task automatic set_entry(input int idx, input logic [7:0] y, input logic [7:0] x,
                             input logic [7:0] code, input logic [7:0] attr);
        apb_write(6'(4 * idx), y);
        apb_write(6'(4 * idx + 1), x);
        apb_write(6'(4 * idx + 2), code);
        apb_write(6'(4 * idx + 3), attr);
    endtask

    // No entry covers lines below 0x80
    task automatic clear_table();
        int i;
        for (i = 0; i < obj_pkg::OBJ_COUNT; i++) begin
            set_entry(i, 8'h80, 8'h00, 8'h00, 8'h00);
        end
    endtask

    // One video line that shows the previous render while v is drawn
    task automatic run_line(input logic [7:0] v);
        int h;
        int c;
        exp_disp = exp_next;
        for (h = 0; h < obj_pkg::LINE_W; h++) begin
            exp_next[h] = ref_pixel(h, v);
        end
        for (c = 0; c < LINE_CLKS; c++) begin
            @(posedge clk);
            line_start <= (c == 0);
            vrender    <= v;
            pxl_cen    <= (c >= 2) && (c < 514) && (c % 2 == 0);
            hdump      <= 8'((c - 2) / 2);
        end
    endtask

    // Only unused attr bits change, so the render stays the same
    task automatic bus_traffic();
        int         i;
        int         r;
        logic [5:0] a;
        for (i = 0; i < 12; i++) begin
            r = $random(seed);
            a = 6'(r);
            if (r[8]) begin
                a[1:0] = 2'b11;
                apb_write(a, {r[15:14], obj_table[a][5:0]});
            end else begin
                apb_check(a);
            end
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = pix_errors + seq_errors;
    endtask

    task automatic end_test();
        int errs;
        run_line(8'h00);
        errs = pix_errors + seq_errors - err_base;
        if (errs == 0) begin
            $display("%s: pass", cur_test);
        end else begin
            $display("%s: FAIL with %0d errors", cur_test, errs);
        end
    endtask

    initial begin
        int         i;
        int         r;
        int         line;
        int         reqs0;
        logic [7:0] v;
        seed       = 32'hd06595f7;
        rst        = 1'b1;
        apb        = '0;
        line_start = 1'b0;
        vrender    = 8'h00;
        hdump      = 8'h00;
        pxl_cen    = 1'b0;
        seq_checks = 0;
        seq_errors = 0;
        for (i = 0; i < obj_pkg::LINE_W; i++) begin
            exp_next[i] = 8'h00;
            exp_disp[i] = 8'h00;
        end
        for (i = 0; i < TABLE_BYTES; i++) begin
            obj_table[i] = 8'h00;
        end
        for (i = 0; i < 256; i++) begin
            lat_tab[i] = 1 + int'($unsigned($random(seed)) % 6);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_idle");
        clear_table();
        reqs0 = rom_reqs;
        run_line(8'h40);
        run_line(8'h40);
        seq_checks++;
        if (rom_reqs != reqs0) begin
            seq_errors++;
            $display("reset_idle: ROM was read although no sprite covers the line");
        end
        end_test();

        start_test("table_rw");
        for (i = 0; i < TABLE_BYTES; i++) begin
            apb_write(6'(i), 8'(i * 37 + 8'h5b));
        end
        for (i = 0; i < TABLE_BYTES; i++) begin
            apb_check(6'(i));
        end
        end_test();

        // Bottom rows and clipping past x = 255
        start_test("single_sprite");
        clear_table();
        set_entry(0, 8'h50, 8'hfa, 8'h53, 8'h05);
        run_line(8'h50);
        run_line(8'h53);
        run_line(8'h5e);
        run_line(8'h5f);
        run_line(8'h60);
        end_test();

        start_test("flips");
        clear_table();
        set_entry(0, 8'h30, 8'h10, 8'h6c, 8'h01);
        set_entry(1, 8'h30, 8'h40, 8'h6c, 8'h12);
        set_entry(2, 8'h30, 8'h70, 8'h6c, 8'h23);
        set_entry(3, 8'h30, 8'hfc, 8'h6c, 8'h34);
        run_line(8'h32);
        run_line(8'h3d);
        end_test();

        start_test("overlap");
        clear_table();
        set_entry(0, 8'ha0, 8'h20, 8'h53, 8'h02);
        set_entry(1, 8'ha0, 8'h23, 8'h53, 8'h09);
        set_entry(2, 8'ha1, 8'h26, 8'h35, 8'h1e);
        run_line(8'ha3);
        run_line(8'ha7);
        end_test();

        start_test("random_traffic");
        for (line = 0; line < 8; line++) begin
            v = 8'($random(seed));
            for (i = 0; i < TABLE_BYTES; i++) begin
                r = $random(seed);
                if (i % 4 == 0) begin
                    apb_write(6'(i), v - 8'($unsigned(r) % 24));
                end else begin
                    apb_write(6'(i), 8'(r));
                end
            end
            fork
                run_line(v);
                bus_traffic();
            join
        end
        end_test();

        $display("Checks %0d, errors %0d", pix_checks + seq_checks,
                 pix_errors + seq_errors);
        if (pix_errors + seq_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- obj_engine.f
design/obj_pkg.sv
design/obj_ram_arbiter.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_line_buffer.sv
design/obj_engine.sv
test/obj_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= obj_engine_tb
FILELIST  ?= obj_engine.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_TEXT ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
